// ==== files.f ====
hdl/net_cfg_pkg.sv
hdl/stream_pkg.sv
hdl/byte_stream_if.sv
hdl/payload_frame_fifo.sv
hdl/ip_header_checksum.sv
hdl/udp_frame_builder.sv
hdl/udp_stream.sv
verification/tb_clock_gen.sv
verification/tb_udp_stream.sv

// ==== Makefile ====
TOP := tb_udp_stream

.PHONY: all run lint clean

all: run

obj_dir/V$(TOP): files.f $(wildcard hdl/*.sv verification/*.sv)
	verilator --binary --timing --assert --top-module $(TOP) -f files.f

run: obj_dir/V$(TOP)
	@out="$$(./obj_dir/V$(TOP))"; \
	echo "$$out"; \
	echo "$$out" | grep -qx "Test passed"

lint:
	verilator --lint-only -Wall --timing --top-module $(TOP) -f files.f

clean:
	rm -rf obj_dir

// ==== verification/udp_stream_golden.hex ====
// frame count, then per frame: payload length, expected IP header checksum,
// and the payload bytes
0005
0001 b761 a5
0011 b751 10 11 12 13 14 15 16 17 18 19 1a 1b 1c 1d 1e 1f 20
0012 b750 30 31 32 33 34 35 36 37 38 39 3a 3b 3c 3d 3e 3f 40 41
0028 b73a
00 01 02 03 04 05 06 07 08 09 0a 0b 0c 0d 0e 0f 10 11 12 13
14 15 16 17 18 19 1a 1b 1c 1d 1e 1f 20 21 22 23 24 25 26 27
0040 b722
c0 c1 c2 c3 c4 c5 c6 c7 c8 c9 ca cb cc cd ce cf
d0 d1 d2 d3 d4 d5 d6 d7 d8 d9 da db dc dd de df
e0 e1 e2 e3 e4 e5 e6 e7 e8 e9 ea eb ec ed ee ef
f0 f1 f2 f3 f4 f5 f6 f7 f8 f9 fa fb fc fd fe ff

// ==== verification/tb_udp_stream.sv ====
// Testbench for the UDP transmit streamer.
// Payloads and expected IP checksums come from the golden hex file; each frame
// is sent on tx_* and eth_* is checked byte by byte under random back-pressure.

`timescale 1ns/1ps
`default_nettype none

module tb_udp_stream;

    localparam int hdr_bytes  = 42;
    localparam int min_frame  = 60;
    localparam int max_frames = 8;

    logic       clk;
    logic       arst_n;
    logic [7:0] tx_data;
    logic       tx_valid;
    logic       tx_ready;
    logic       tx_last;
    logic [7:0] eth_data;
    logic       eth_valid;
    logic       eth_ready;
    logic       eth_last;

    logic [15:0] golden_mem [256];
    int          frame_len_q [$];
    logic [15:0] frame_cs_q [$];
    int          frame_off_q [$];

    // expected output with one entry per byte
    logic [7:0] exp_data [$];
    bit         exp_last [$];
    int         exp_frame [$];
    int         exp_pos [$];

    integer seed;
    int     exp_total;
    int     rx_count;
    int     data_errors;
    int     extra_bytes;
    int     reset_errors;
    int     file_errors;
    int     cycle_cnt;
    int     cycle_limit;
    bit     limit_set;

    tb_clock_gen #(.period_ns(20), .reset_cycles(4)) clock_i (.clk(clk), .arst_n(arst_n));

    udp_stream dut_i (
        .clk       (clk),
        .arst_n    (arst_n),
        .tx_data   (tx_data),
        .tx_valid  (tx_valid),
        .tx_ready  (tx_ready),
        .tx_last   (tx_last),
        .eth_data  (eth_data),
        .eth_valid (eth_valid),
        .eth_ready (eth_ready),
        .eth_last  (eth_last)
    );

    function automatic logic [15:0] golden_word(input int idx);
        return golden_mem[8'(idx)];
    endfunction

    task automatic load_golden();
        int count;
        int idx;
        int len;
        int f;
        $readmemh("verification/udp_stream_golden.hex", golden_mem);
        count = int'(golden_word(0));
        if (count < 1 || count > max_frames) begin
            $display("golden file holds %0d frames, expected 1 to %0d", count, max_frames);
            file_errors++;
            count = 0;
        end
        idx = 1;
        for (f = 0; f < count && file_errors == 0; f++) begin
            len = int'(golden_word(idx));
            if (len < 1 || idx + 2 + len > 256) begin
                $display("golden file frame %0d has an unusable payload length %0d", f, len);
                file_errors++;
            end else begin
                frame_len_q.push_back(len);
                frame_cs_q.push_back(golden_word(idx + 1));
                frame_off_q.push_back(idx + 2);
                idx = idx + 2 + len;
            end
        end
    endtask

    // dest 02:00:00:00:00:01, src 02:00:00:00:00:00, 192.168.1.10 to .20, port 1234
    function automatic logic [7:0] header_byte(input int pos, input int len,
                                               input logic [15:0] cs);
        logic [hdr_bytes*8-1:0] hdr;
        hdr = {48'h02_00_00_00_00_01, 48'h02_00_00_00_00_00, 16'h0800,
               16'h4500, 16'(28 + len), 32'h0000_4000, 16'h4011, cs,
               32'hc0a8_010a, 32'hc0a8_0114,
               16'd1234, 16'd1234, 16'(8 + len), 16'h0000};
        return hdr[8*(hdr_bytes - 1 - pos) +: 8];
    endfunction

    function automatic string field_name(input int pos, input int len);
        if (pos < 6)  return "destination MAC";
        if (pos < 12) return "source MAC";
        if (pos < 14) return "EtherType";
        if (pos < 16) return "IP version/TOS";
        if (pos < 18) return "IP total length";
        if (pos < 22) return "IP ID/flags";
        if (pos < 24) return "IP TTL/protocol";
        if (pos < 26) return "IP checksum";
        if (pos < 34) return "IP addresses";
        if (pos < 38) return "UDP ports";
        if (pos < 40) return "UDP length";
        if (pos < 42) return "UDP checksum";
        if (pos < hdr_bytes + len) return "payload";
        return "padding";
    endfunction

    task automatic build_expected(input int f);
        int          len;
        int          frame_bytes;
        int          pos;
        logic [15:0] word;
        logic [7:0]  value;
        len = frame_len_q[f];
        frame_bytes = (hdr_bytes + len < min_frame) ? min_frame : hdr_bytes + len;
        for (pos = 0; pos < frame_bytes; pos++) begin
            word = golden_word(frame_off_q[f] + pos - hdr_bytes);
            if (pos < hdr_bytes) begin
                value = header_byte(pos, len, frame_cs_q[f]);
            end else if (pos < hdr_bytes + len) begin
                value = word[7:0];
            end else begin
                value = 8'h00;
            end
            exp_data.push_back(value);
            exp_last.push_back(pos == frame_bytes - 1);
            exp_frame.push_back(f);
            exp_pos.push_back(pos);
        end
    endtask

    // starts on a falling edge and returns once the frame's last byte is taken
    task automatic send_frame(input int f);
        int          k;
        logic [15:0] word;
        for (k = 0; k < frame_len_q[f]; k++) begin
            word     = golden_word(frame_off_q[f] + k);
            tx_data  = word[7:0];
            tx_last  = (k == frame_len_q[f] - 1);
            tx_valid = 1'b1;
            #1;
            while (!tx_ready) begin
                @(negedge clk);
                #1;
            end
            @(negedge clk);
        end
        tx_valid = 1'b0;
        tx_last  = 1'b0;
    endtask

    task automatic check_output_byte();
        int    n;
        string name;
        n = rx_count;
        if (n >= exp_total) begin
            $display("output byte 0x%02h at %0t arrived after all frames were complete",
                     eth_data, $time);
            extra_bytes++;
        end else begin
            name = field_name(exp_pos[n], frame_len_q[exp_frame[n]]);
            assert (eth_data == exp_data[n]) else begin
                $display("CHECK FAILED at %0t: frame %0d %s byte %0d is 0x%02h, expected 0x%02h",
                         $time, exp_frame[n], name, exp_pos[n], eth_data, exp_data[n]);
                data_errors++;
            end
            assert (eth_last == exp_last[n]) else begin
                $display("CHECK FAILED at %0t: frame %0d eth_last on %s byte %0d is %b",
                         $time, exp_frame[n], name, exp_pos[n], eth_last);
                data_errors++;
            end
            rx_count++;
        end
    endtask

    // eth_ready is drawn on the falling edge and the output sampled just after
    initial begin
        seed        = 32'hd678_f89f;
        eth_ready   = 1'b0;
        rx_count    = 0;
        data_errors = 0;
        extra_bytes = 0;
        forever begin
            @(negedge clk);
            eth_ready = arst_n && (($random(seed) % 4) != 0);
            #1;
            if (eth_valid && eth_ready) begin
                check_output_byte();
            end
        end
    end

    initial begin
        cycle_cnt = 0;
        while (!limit_set || cycle_cnt < cycle_limit) begin
            @(posedge clk);
            cycle_cnt++;
        end
        $display("timeout: the frames did not complete within %0d cycles", cycle_limit);
        $display("Test failed");
        $finish;
    end

    initial begin
        int f;
        tx_data      = 8'h00;
        tx_valid     = 1'b0;
        tx_last      = 1'b0;
        reset_errors = 0;
        file_errors  = 0;
        limit_set    = 1'b0;
        load_golden();
        for (f = 0; f < frame_len_q.size(); f++) begin
            build_expected(f);
        end
        exp_total   = exp_data.size();
        cycle_limit = 10 * exp_total + 200;
        limit_set   = 1'b1;

        wait (arst_n === 1'b1);
        @(negedge clk);
        #1;
        assert (eth_valid == 1'b0) else begin
            $display("CHECK FAILED at %0t: eth_valid after reset is %b, expected 0",
                     $time, eth_valid);
            reset_errors++;
        end
        assert (tx_ready == 1'b1) else begin
            $display("CHECK FAILED at %0t: tx_ready after reset is %b, expected 1",
                     $time, tx_ready);
            reset_errors++;
        end

        @(negedge clk);
        for (f = 0; f < frame_len_q.size(); f++) begin
            send_frame(f);
        end
        wait (rx_count >= exp_total);
        // room for any stray byte after the last frame
        repeat (20) @(negedge clk);

        $display("errors: %0d output mismatches, %0d extra bytes, %0d reset state, %0d golden file",
                 data_errors, extra_bytes, reset_errors, file_errors);
        if (data_errors + extra_bytes + reset_errors + file_errors == 0) begin
            $display("Test passed");
        end else begin
            $display("Test failed");
        end
        $finish;
    end

endmodule

`default_nettype wire

// ==== verification/tb_clock_gen.sv ====
// Clock and reset source for the testbench.
// Free-running clock; arst_n is held low for reset_cycles rising edges and
// released on a falling edge.

`timescale 1ns/1ps
`default_nettype none

module tb_clock_gen #(
    parameter int period_ns    = 20,
    parameter int reset_cycles = 4
) (
    output logic clk,
    output logic arst_n
);

    initial begin
        clk = 1'b0;
        forever begin
            #(period_ns / 2) clk = ~clk;
        end
    end

    initial begin
        arst_n = 1'b0;
        repeat (reset_cycles) @(posedge clk);
        @(negedge clk);
        arst_n = 1'b1;
    end

endmodule

`default_nettype wire

// ==== hdl/udp_stream.sv ====
// UDP transmit streamer top level.
// Payload bytes on tx_* are buffered per frame and sent on eth_* as complete
// Ethernet frames carrying IPv4 and UDP headers.

`timescale 1ns/1ps
`default_nettype none

module udp_stream #(
    parameter net_cfg_pkg::mac_addr_t local_mac   = net_cfg_pkg::default_local_mac,
    parameter net_cfg_pkg::mac_addr_t dest_mac    = net_cfg_pkg::default_dest_mac,
    parameter net_cfg_pkg::ip_addr_t  local_ip    = net_cfg_pkg::default_local_ip,
    parameter net_cfg_pkg::ip_addr_t  dest_ip     = net_cfg_pkg::default_dest_ip,
    parameter net_cfg_pkg::udp_port_t udp_port    = net_cfg_pkg::default_udp_port,
    parameter int                     fifo_depth  = 256,
    parameter int                     frame_slots = 8
) (
    input  logic              clk,
    input  logic              arst_n,
    input  stream_pkg::byte_t tx_data,
    input  logic              tx_valid,
    output logic              tx_ready,
    input  logic              tx_last,
    output stream_pkg::byte_t eth_data,
    output logic              eth_valid,
    input  logic              eth_ready,
    output logic              eth_last
);

    import net_cfg_pkg::*;
    import stream_pkg::*;

    payload_len_t frame_len;
    logic         frame_avail;
    logic         frame_take;
    logic         cs_start;
    length16_t    checksum;

    // payload bytes from the FIFO into the builder
    byte_stream_if frame_s ();

    payload_frame_fifo #(
        .fifo_depth  (fifo_depth),
        .frame_slots (frame_slots)
    ) u_fifo (
        .clk         (clk),
        .arst_n      (arst_n),
        .tx_data     (tx_data),
        .tx_valid    (tx_valid),
        .tx_ready    (tx_ready),
        .tx_last     (tx_last),
        .frame_avail (frame_avail),
        .frame_len   (frame_len),
        .frame_take  (frame_take),
        .frame_s     (frame_s.source)
    );

    ip_header_checksum u_checksum (
        .clk         (clk),
        .arst_n      (arst_n),
        .start       (cs_start),
        .payload_len (frame_len),
        .src_ip      (local_ip),
        .dst_ip      (dest_ip),
        .checksum    (checksum)
    );

    udp_frame_builder #(
        .local_mac (local_mac),
        .dest_mac  (dest_mac),
        .local_ip  (local_ip),
        .dest_ip   (dest_ip),
        .udp_port  (udp_port)
    ) u_builder (
        .clk         (clk),
        .arst_n      (arst_n),
        .frame_avail (frame_avail),
        .frame_len   (frame_len),
        .frame_take  (frame_take),
        .cs_start    (cs_start),
        .checksum    (checksum),
        .frame_s     (frame_s.sink),
        .eth_data    (eth_data),
        .eth_valid   (eth_valid),
        .eth_ready   (eth_ready),
        .eth_last    (eth_last)
    );

endmodule

`default_nettype wire

// ==== hdl/udp_frame_builder.sv ====
// Builds one Ethernet/IPv4/UDP frame per queued payload.
// Takes a frame length from the FIFO, sends the 42 header bytes, passes the
// payload through from frame_s and pads with zeros to the minimum frame size.

`timescale 1ns/1ps
`default_nettype none

module udp_frame_builder #(
    parameter net_cfg_pkg::mac_addr_t local_mac = net_cfg_pkg::default_local_mac,
    parameter net_cfg_pkg::mac_addr_t dest_mac  = net_cfg_pkg::default_dest_mac,
    parameter net_cfg_pkg::ip_addr_t  local_ip  = net_cfg_pkg::default_local_ip,
    parameter net_cfg_pkg::ip_addr_t  dest_ip   = net_cfg_pkg::default_dest_ip,
    parameter net_cfg_pkg::udp_port_t udp_port  = net_cfg_pkg::default_udp_port
) (
    input  logic                     clk,
    input  logic                     arst_n,
    input  logic                     frame_avail,
    input  stream_pkg::payload_len_t frame_len,
    output logic                     frame_take,
    output logic                     cs_start,
    input  net_cfg_pkg::length16_t   checksum,
    byte_stream_if.sink              frame_s,
    output stream_pkg::byte_t        eth_data,
    output logic                     eth_valid,
    input  logic                     eth_ready,
    output logic                     eth_last
);

    import net_cfg_pkg::*;
    import stream_pkg::*;

    localparam int hdr_total = eth_hdr_bytes + ip_hdr_bytes + udp_hdr_bytes;

    build_state_t            state;
    payload_len_t            byte_cnt;
    payload_len_t            len_q;
    length16_t               ip_len;
    length16_t               udp_len;
    logic                    short_frame;
    logic [hdr_total*8-1:0]  hdr_vec;

    assign ip_len  = length16_t'(ip_hdr_bytes + udp_hdr_bytes) + len_q;
    assign udp_len = length16_t'(udp_hdr_bytes) + len_q;

    // whole header in network byte order, first byte in the top bits
    assign hdr_vec = {
        dest_mac, local_mac, eth_type_ipv4,
        8'h45, 8'h00, ip_len, 16'h0000, 16'h4000,
        ip_ttl_default, ip_proto_udp, checksum, local_ip, dest_ip,
        udp_port, udp_port, udp_len, 16'h0000
    };

    // the byte now on the output still leaves the frame under 60 bytes
    assign short_frame = byte_cnt < payload_len_t'(eth_min_bytes - 1);

    always_comb begin
        frame_take    = 1'b0;
        cs_start      = 1'b0;
        frame_s.ready = 1'b0;
        eth_valid     = 1'b0;
        eth_data      = '0;
        eth_last      = 1'b0;
        case (state)
            idle: begin
                frame_take = frame_avail;
                cs_start   = frame_avail;
            end
            hdr: begin
                eth_valid = 1'b1;
                eth_data  = hdr_vec[8*(hdr_total - 1 - int'(byte_cnt)) +: 8];
            end
            payload: begin
                eth_valid     = frame_s.valid;
                eth_data      = frame_s.data;
                eth_last      = frame_s.last && !short_frame;
                frame_s.ready = eth_ready;
            end
            pad: begin
                eth_valid = 1'b1;
                eth_last  = byte_cnt == payload_len_t'(eth_min_bytes - 1);
            end
            default: begin
                eth_valid = 1'b0;
            end
        endcase
    end

    // length of the frame in flight
    always_ff @(posedge clk) begin
        if (state == idle && frame_avail) begin
            len_q <= frame_len;
        end
    end

    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            state    <= idle;
            byte_cnt <= '0;
        end else begin
            case (state)
                idle: begin
                    if (frame_avail) begin
                        byte_cnt <= '0;
                        state    <= hdr;
                    end
                end
                hdr: begin
                    if (eth_ready) begin
                        byte_cnt <= byte_cnt + 1'b1;
                        if (byte_cnt == payload_len_t'(hdr_total - 1)) begin
                            state <= payload;
                        end
                    end
                end
                payload: begin
                    if (frame_s.valid && eth_ready) begin
                        byte_cnt <= byte_cnt + 1'b1;
                        if (frame_s.last) begin
                            state <= short_frame ? pad : idle;
                        end
                    end
                end
                pad: begin
                    if (eth_ready) begin
                        byte_cnt <= byte_cnt + 1'b1;
                        if (eth_last) begin
                            state <= idle;
                        end
                    end
                end
                default: begin
                    state <= idle;
                end
            endcase
        end
    end

    // a stalled byte stays put until the sink takes it
    a_hold_on_stall: assert property (@(posedge clk) disable iff (!arst_n)
        eth_valid && !eth_ready |=> eth_valid && $stable(eth_data) && $stable(eth_last));

endmodule

`default_nettype wire

// ==== hdl/ip_header_checksum.sv ====
// IPv4 header checksum for one outgoing UDP frame.
// A start pulse samples the payload length and addresses; the checksum is
// valid from the following cycle and holds until the next start.

`timescale 1ns/1ps
`default_nettype none

module ip_header_checksum (
    input  logic                     clk,
    input  logic                     arst_n,
    input  logic                     start,
    input  stream_pkg::payload_len_t payload_len,
    input  net_cfg_pkg::ip_addr_t    src_ip,
    input  net_cfg_pkg::ip_addr_t    dst_ip,
    output net_cfg_pkg::length16_t   checksum
);

    import net_cfg_pkg::*;

    length16_t   total_len;
    logic [31:0] word_sum;
    logic [16:0] fold_once;
    logic [15:0] fold_twice;

    assign total_len = length16_t'(ip_hdr_bytes + udp_hdr_bytes) + payload_len;

    // identification and checksum words are zero and drop out of the sum
    assign word_sum = 32'h0000_4500 + 32'(total_len) + 32'h0000_4000
                    + 32'({ip_ttl_default, ip_proto_udp})
                    + 32'(src_ip[31:16]) + 32'(src_ip[15:0])
                    + 32'(dst_ip[31:16]) + 32'(dst_ip[15:0]);

    // end-around carries, two folds are enough for nine words
    assign fold_once  = 17'(word_sum[15:0]) + 17'(word_sum[31:16]);
    assign fold_twice = fold_once[15:0] + 16'(fold_once[16]);

    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            checksum <= '0;
        end else if (start) begin
            checksum <= ~fold_twice;
        end
    end

    // one start per frame, the builder waits a cycle before using the result
    a_single_start: assert property (@(posedge clk) disable iff (!arst_n)
        start |=> !start);

endmodule

`default_nettype wire

// ==== hdl/payload_frame_fifo.sv ====
// Frame FIFO for the UDP payload stream.
// Bytes are stored as they arrive; a frame is released on frame_s and its
// length queued on frame_len only once its last byte has been written.
// fifo_depth and frame_slots must be powers of two, frame_slots at least 2.

`timescale 1ns/1ps
`default_nettype none

module payload_frame_fifo #(
    parameter int fifo_depth  = 256,
    parameter int frame_slots = 8
) (
    input  logic                     clk,
    input  logic                     arst_n,
    input  stream_pkg::byte_t        tx_data,
    input  logic                     tx_valid,
    output logic                     tx_ready,
    input  logic                     tx_last,
    output logic                     frame_avail,
    output stream_pkg::payload_len_t frame_len,
    input  logic                     frame_take,
    byte_stream_if.source            frame_s
);

    import stream_pkg::*;

    localparam int addr_w = $clog2(fifo_depth);
    localparam int slot_w = $clog2(frame_slots);

    // one extra bit to tell full from empty
    typedef logic [addr_w:0] ptr_t;
    typedef logic [slot_w:0] slot_ptr_t;

    byte_t        data_mem [fifo_depth];
    logic         last_mem [fifo_depth];
    payload_len_t len_mem [frame_slots];

    ptr_t         wr_ptr;
    ptr_t         rd_ptr;
    ptr_t         commit_ptr;
    ptr_t         store_level;
    slot_ptr_t    len_wr;
    slot_ptr_t    len_rd;
    slot_ptr_t    slot_level;
    payload_len_t frame_cnt;
    logic         wr_en;
    logic         rd_en;

    assign store_level = wr_ptr - rd_ptr;
    assign slot_level  = len_wr - len_rd;

    // stall on a full byte store or when every length slot is in use
    assign tx_ready = (store_level != ptr_t'(fifo_depth)) &&
                      (slot_level != slot_ptr_t'(frame_slots));

    assign wr_en = tx_valid && tx_ready;
    assign rd_en = frame_s.valid && frame_s.ready;

    always_ff @(posedge clk) begin
        if (wr_en) begin
            data_mem[wr_ptr[addr_w-1:0]] <= tx_data;
            last_mem[wr_ptr[addr_w-1:0]] <= tx_last;
        end
        if (wr_en && tx_last) begin
            len_mem[len_wr[slot_w-1:0]] <= frame_cnt + 1'b1;
        end
    end

    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            wr_ptr     <= '0;
            rd_ptr     <= '0;
            commit_ptr <= '0;
            len_wr     <= '0;
            len_rd     <= '0;
            frame_cnt  <= '0;
        end else begin
            if (wr_en) begin
                wr_ptr <= wr_ptr + 1'b1;
                if (tx_last) begin
                    // frame complete, make its bytes visible to the reader
                    commit_ptr <= wr_ptr + 1'b1;
                    len_wr     <= len_wr + 1'b1;
                    frame_cnt  <= '0;
                end else begin
                    frame_cnt <= frame_cnt + 1'b1;
                end
            end
            if (rd_en) begin
                rd_ptr <= rd_ptr + 1'b1;
            end
            if (frame_take) begin
                len_rd <= len_rd + 1'b1;
            end
        end
    end

    // only committed bytes are offered downstream
    assign frame_s.data  = data_mem[rd_ptr[addr_w-1:0]];
    assign frame_s.last  = last_mem[rd_ptr[addr_w-1:0]];
    assign frame_s.valid = rd_ptr != commit_ptr;

    assign frame_avail = len_wr != len_rd;
    assign frame_len   = len_mem[len_rd[slot_w-1:0]];

    // writer stays at most one full store ahead of the reader
    a_no_overrun: assert property (@(posedge clk) disable iff (!arst_n)
        store_level <= ptr_t'(fifo_depth));

endmodule

`default_nettype wire

// ==== hdl/byte_stream_if.sv ====
// Byte stream with valid, ready and last.
// A byte moves on a clk edge where valid and ready are both high; the source
// holds data, valid and last steady until then.

`timescale 1ns/1ps
`default_nettype none

interface byte_stream_if;

    import stream_pkg::*;

    byte_t data;
    logic  valid;
    logic  ready;
    logic  last;

    modport source (
        output data,
        output valid,
        output last,
        input  ready
    );

    modport sink (
        input  data,
        input  valid,
        input  last,
        output ready
    );

endinterface

`default_nettype wire

// ==== hdl/stream_pkg.sv ====
// Byte stream types and the frame builder state encoding.
// Imported by the FIFO, the checksum unit and the frame builder.

`default_nettype none

package stream_pkg;

    // one byte of a stream
    typedef logic [7:0] byte_t;

    // payload length in bytes, as counted by the FIFO
    typedef logic [15:0] payload_len_t;

    // builder sequence: wait, header bytes, payload, zero padding
    typedef enum logic [1:0] {
        idle,
        hdr,
        payload,
        pad
    } build_state_t;

endpackage

`default_nettype wire

// ==== hdl/net_cfg_pkg.sv ====
// Ethernet, IPv4 and UDP field types and header constants for the UDP transmit path.
// The default addresses are used as parameter defaults at the top level.

`default_nettype none

package net_cfg_pkg;

    typedef logic [47:0] mac_addr_t;
    typedef logic [31:0] ip_addr_t;
    typedef logic [15:0] udp_port_t;

    // IP total length and UDP length fields
    typedef logic [15:0] length16_t;

    localparam logic [15:0] eth_type_ipv4  = 16'h0800;
    localparam logic [7:0]  ip_proto_udp   = 8'd17;
    localparam logic [7:0]  ip_ttl_default = 8'd64;

    // header sizes in bytes
    localparam int eth_hdr_bytes = 14;
    localparam int ip_hdr_bytes  = 20;
    localparam int udp_hdr_bytes = 8;

    // minimum Ethernet frame without FCS
    localparam int eth_min_bytes = 60;

    // locally administered addresses
    localparam mac_addr_t default_local_mac = 48'h02_00_00_00_00_00;
    localparam mac_addr_t default_dest_mac  = 48'h02_00_00_00_00_01;

    localparam ip_addr_t default_local_ip = {8'd192, 8'd168, 8'd1, 8'd10};
    localparam ip_addr_t default_dest_ip  = {8'd192, 8'd168, 8'd1, 8'd20};

    localparam udp_port_t default_udp_port = 16'd1234;

endpackage

`default_nettype wire
